/* logic/cavlc_consts.svh */
`ifndef CAVLC_CONSTS_SVH
`define CAVLC_CONSTS_SVH

// Block geometry
`define BLK_COEFFS  16
`define COEFF_W     16
`define MAX_RUNS    15

// Field widths
`define CNT_W       5
`define RUN_W       4
`define CODE_W      32
`define BITS_W      6
`define AXI_ADDR_W  4
`define AXI_DATA_W  32

`define FIFO_DEPTH  4

// Register map, byte offsets
`define REG_CTRL    4'h0
`define REG_BLKCNT  4'h4
`define REG_LASTLEN 4'h8

`endif

/* logic/cavlcPkg.sv */
`include "cavlc_consts.svh"

package cavlcPkg;

    // Coefficient 0 sits in the low bits
    typedef logic signed [`BLK_COEFFS-1:0][`COEFF_W-1:0] coeffBlock_t;

    // Runs are stored highest-frequency first
    typedef struct packed {
        logic [`CNT_W-1:0]                 totalCoeff;
        logic [`CNT_W-1:0]                 totalZeros;
        logic [`CNT_W-1:0]                 runCnt;
        logic [`MAX_RUNS-1:0][`RUN_W-1:0]  runs;
    } runList_t;

    typedef struct packed {
        logic [`CNT_W-1:0]   totalCoeff;
        logic [`CNT_W-1:0]   totalZeros;
        logic [`CODE_W-1:0]  code;
        logic [`BITS_W-1:0]  bits;
    } runCode_t;

    typedef struct packed {
        logic [`AXI_ADDR_W-1:0]     awaddr;
        logic                       awvalid;
        logic [`AXI_DATA_W-1:0]     wdata;
        logic [`AXI_DATA_W/8-1:0]   wstrb;
        logic                       wvalid;
        logic                       bready;
        logic [`AXI_ADDR_W-1:0]     araddr;
        logic                       arvalid;
        logic                       rready;
    } axiLiteReq_t;

    typedef struct packed {
        logic                    awready;
        logic                    wready;
        logic [1:0]              bresp;
        logic                    bvalid;
        logic                    arready;
        logic [`AXI_DATA_W-1:0]  rdata;
        logic [1:0]              rresp;
        logic                    rvalid;
    } axiLiteRsp_t;

endpackage

/* logic/syncFifo.sv */
`include "cavlc_consts.svh"

module syncFifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = `FIFO_DEPTH
) (
    input  logic     clk,
    input  logic     enc_rst,
    input  logic     wrValid,
    input  payload_t wrData,
    output logic     wrReady,
    output logic     rdValid,
    output payload_t rdData,
    input  logic     rdReady
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t   mem [DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [CNT_W-1:0] count;
    logic             doWrite;
    logic             doRead;

    assign wrReady = (count != CNT_W'(DEPTH));
    assign rdValid = (count != '0);
    assign rdData  = mem[rdPtr];

    assign doWrite = wrValid && wrReady;
    assign doRead  = rdValid && rdReady;

    always_ff @(posedge clk) begin
        if (doWrite) begin
            mem[wrPtr] <= wrData;
        end
    end

    always_ff @(posedge clk) begin
        if (enc_rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doWrite) begin
                wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (doRead) begin
                rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            // Occupancy moves only when one side fires alone
            if (doWrite && !doRead) begin
                count <= count + 1'b1;
            end else if (doRead && !doWrite) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* logic/zeroRunScanner.sv */
`include "cavlc_consts.svh"

module zeroRunScanner (
    input  logic                  clk,
    input  logic                  enc_rst,
    input  logic                  codeEnable,
    input  logic                  blkValid,
    input  cavlcPkg::coeffBlock_t blkData,
    output logic                  blkReady,
    output logic                  listValid,
    output cavlcPkg::runList_t    listData,
    input  logic                  listReady
);

    import cavlcPkg::*;

    runList_t scan;

    // Walk from the highest frequency down to coefficient 0
    always_comb begin
        logic              seen;
        logic [`RUN_W-1:0] zeroRun;
        logic [`RUN_W-1:0] runPos;
        scan    = '0;
        seen    = 1'b0;
        zeroRun = '0;
        runPos  = '0;
        for (int i = `BLK_COEFFS - 1; i >= 0; i--) begin
            if (blkData[i] != '0) begin
                scan.totalCoeff = scan.totalCoeff + 1'b1;
                // Gap down to this coefficient belongs to the one above
                if (seen) begin
                    scan.runs[runPos] = zeroRun;
                    runPos = runPos + 1'b1;
                end
                seen    = 1'b1;
                zeroRun = '0;
            end else if (seen) begin
                zeroRun         = zeroRun + 1'b1;
                scan.totalZeros = scan.totalZeros + 1'b1;
            end
        end
        // Run of the last coefficient is implied, never coded
        if (scan.totalCoeff != '0) begin
            scan.runCnt = scan.totalCoeff - 1'b1;
        end
    end

    assign blkReady = codeEnable && (!listValid || listReady);

    always_ff @(posedge clk) begin
        if (enc_rst) begin
            listValid <= 1'b0;
        end else if (blkValid && blkReady) begin
            listValid <= 1'b1;
        end else if (listReady) begin
            listValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (blkValid && blkReady) begin
            listData <= scan;
        end
    end

endmodule

/* logic/runBeforeEncoder.sv */
`include "cavlc_consts.svh"

module runBeforeEncoder (
    input  logic               clk,
    input  logic               enc_rst,
    input  logic               listValid,
    input  cavlcPkg::runList_t listData,
    output logic               listReady,
    output logic               resValid,
    output cavlcPkg::runCode_t resData,
    input  logic               resReady,
    output logic               blockDone
);

    import cavlcPkg::*;

    runList_t           listReg;
    logic               busy;
    logic               loadNow;
    logic               stopNow;
    logic [`CNT_W-1:0]  runIdx;
    logic [`CNT_W-1:0]  zerosLeft;
    logic [`RUN_W-1:0]  curRun;
    logic [6:0]         entry;
    logic [10:0]        cw;
    logic [3:0]         cwLen;
    logic [`CODE_W-1:0] codeReg;
    logic [`BITS_W-1:0] bitsReg;

    assign listReady = !busy && (!resValid || resReady);
    assign loadNow   = listValid && listReady;
    assign stopNow   = (zerosLeft == '0) || (runIdx == listReg.runCnt);
    assign curRun    = (runIdx < `CNT_W'(`MAX_RUNS)) ? listReg.runs[runIdx[3:0]] : '0;

    // Short table for zerosLeft up to 6, entry is {length, code}
    always_comb begin
        case ({zerosLeft[2:0], curRun})
            {3'd1, 4'd0}: entry = {4'd1, 3'b001};
            {3'd1, 4'd1}: entry = {4'd1, 3'b000};
            {3'd2, 4'd0}: entry = {4'd1, 3'b001};
            {3'd2, 4'd1}: entry = {4'd2, 3'b001};
            {3'd2, 4'd2}: entry = {4'd2, 3'b000};
            {3'd3, 4'd0}: entry = {4'd2, 3'b011};
            {3'd3, 4'd1}: entry = {4'd2, 3'b010};
            {3'd3, 4'd2}: entry = {4'd2, 3'b001};
            {3'd3, 4'd3}: entry = {4'd2, 3'b000};
            {3'd4, 4'd0}: entry = {4'd2, 3'b011};
            {3'd4, 4'd1}: entry = {4'd2, 3'b010};
            {3'd4, 4'd2}: entry = {4'd2, 3'b001};
            {3'd4, 4'd3}: entry = {4'd3, 3'b001};
            {3'd4, 4'd4}: entry = {4'd3, 3'b000};
            {3'd5, 4'd0}: entry = {4'd2, 3'b011};
            {3'd5, 4'd1}: entry = {4'd2, 3'b010};
            {3'd5, 4'd2}: entry = {4'd3, 3'b011};
            {3'd5, 4'd3}: entry = {4'd3, 3'b010};
            {3'd5, 4'd4}: entry = {4'd3, 3'b001};
            {3'd5, 4'd5}: entry = {4'd3, 3'b000};
            {3'd6, 4'd0}: entry = {4'd2, 3'b011};
            {3'd6, 4'd1}: entry = {4'd3, 3'b000};
            {3'd6, 4'd2}: entry = {4'd3, 3'b001};
            {3'd6, 4'd3}: entry = {4'd3, 3'b011};
            {3'd6, 4'd4}: entry = {4'd3, 3'b010};
            {3'd6, 4'd5}: entry = {4'd3, 3'b101};
            {3'd6, 4'd6}: entry = {4'd3, 3'b100};
            default:      entry = '0;
        endcase
    end

    always_comb begin
        if (zerosLeft > `CNT_W'(6)) begin
            // Above 6 zeros: 3-bit codes, then a unary prefix from run 7
            if (curRun <= 4'd6) begin
                cwLen = 4'd3;
                cw    = {8'b0, 3'd7 - curRun[2:0]};
            end else begin
                cwLen = curRun - 4'd3;
                cw    = 11'd1;
            end
        end else begin
            cwLen = entry[6:3];
            cw    = {8'b0, entry[2:0]};
        end
    end

    always_ff @(posedge clk) begin
        if (enc_rst) begin
            busy      <= 1'b0;
            resValid  <= 1'b0;
            blockDone <= 1'b0;
            runIdx    <= '0;
            zerosLeft <= '0;
        end else begin
            blockDone <= 1'b0;
            if (resValid && resReady) begin
                resValid <= 1'b0;
            end
            if (loadNow) begin
                busy      <= 1'b1;
                runIdx    <= '0;
                zerosLeft <= listData.totalZeros;
            end else if (busy) begin
                if (stopNow) begin
                    busy      <= 1'b0;
                    resValid  <= 1'b1;
                    blockDone <= 1'b1;
                end else begin
                    runIdx    <= runIdx + 1'b1;
                    zerosLeft <= zerosLeft - {1'b0, curRun};
                end
            end
        end
    end

    // Codewords shift in MSB-first
    always_ff @(posedge clk) begin
        if (loadNow) begin
            listReg <= listData;
            codeReg <= '0;
            bitsReg <= '0;
        end else if (busy && !stopNow) begin
            codeReg <= (codeReg << cwLen) | {{(`CODE_W - 11){1'b0}}, cw};
            bitsReg <= bitsReg + {2'b0, cwLen};
        end
    end

    assign resData.totalCoeff = listReg.totalCoeff;
    assign resData.totalZeros = listReg.totalZeros;
    assign resData.code       = codeReg;
    assign resData.bits       = bitsReg;

endmodule

/* logic/runCoderRegs.sv */
`include "cavlc_consts.svh"

module runCoderRegs (
    input  logic                  clk,
    input  logic                  enc_rst,
    input  cavlcPkg::axiLiteReq_t axiReq,
    output cavlcPkg::axiLiteRsp_t axiRsp,
    input  logic                  blockDone,
    input  logic [5:0]            doneBits,
    output logic                  codeEnable
);

    logic [`AXI_DATA_W-1:0] blkCnt;
    logic [`BITS_W-1:0]     lastLen;
    logic [`AXI_DATA_W-1:0] rdataReg;
    logic                   bvalidReg;
    logic                   rvalidReg;
    logic                   wrFire;
    logic                   rdFire;

    // Write takes address and data together
    assign wrFire = axiReq.awvalid && axiReq.wvalid && !bvalidReg;
    assign rdFire = axiReq.arvalid && !rvalidReg;

    assign axiRsp.awready = wrFire;
    assign axiRsp.wready  = wrFire;
    assign axiRsp.bresp   = 2'b00;
    assign axiRsp.bvalid  = bvalidReg;
    assign axiRsp.arready = rdFire;
    assign axiRsp.rdata   = rdataReg;
    assign axiRsp.rresp   = 2'b00;
    assign axiRsp.rvalid  = rvalidReg;

    always_ff @(posedge clk) begin
        if (enc_rst) begin
            bvalidReg <= 1'b0;
            rvalidReg <= 1'b0;
        end else begin
            if (wrFire) begin
                bvalidReg <= 1'b1;
            end else if (axiReq.bready) begin
                bvalidReg <= 1'b0;
            end
            if (rdFire) begin
                rvalidReg <= 1'b1;
            end else if (axiReq.rready) begin
                rvalidReg <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (enc_rst) begin
            codeEnable <= 1'b0;
            blkCnt     <= '0;
            lastLen    <= '0;
        end else begin
            if (wrFire && axiReq.awaddr == `REG_CTRL && axiReq.wstrb[0]) begin
                codeEnable <= axiReq.wdata[0];
            end
            // A host clear wins over a block finishing the same cycle
            if (wrFire && axiReq.awaddr == `REG_BLKCNT) begin
                blkCnt <= '0;
            end else if (blockDone) begin
                blkCnt <= blkCnt + 1'b1;
            end
            if (blockDone) begin
                lastLen <= doneBits;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdFire) begin
            case (axiReq.araddr)
                `REG_CTRL:    rdataReg <= {{(`AXI_DATA_W - 1){1'b0}}, codeEnable};
                `REG_BLKCNT:  rdataReg <= blkCnt;
                `REG_LASTLEN: rdataReg <= {{(`AXI_DATA_W - `BITS_W){1'b0}}, lastLen};
                default:      rdataReg <= '0;
            endcase
        end
    end

endmodule

/* logic/cavlcRunCoder.sv */
`include "cavlc_consts.svh"

module cavlcRunCoder (
    input  logic                  clk,
    input  logic                  enc_rst,
    input  logic                  inValid,
    input  cavlcPkg::coeffBlock_t inData,
    output logic                  inReady,
    output logic                  outValid,
    output cavlcPkg::runCode_t    outData,
    input  logic                  outReady,
    input  cavlcPkg::axiLiteReq_t axiReq,
    output cavlcPkg::axiLiteRsp_t axiRsp
);

    import cavlcPkg::*;

    coeffBlock_t blkData;
    logic        blkValid;
    logic        blkReady;
    runList_t    listData;
    logic        listValid;
    logic        listReady;
    runCode_t    resData;
    logic        resValid;
    logic        resReady;
    logic        blockDone;
    logic        codeEnable;

    syncFifo #(
        .payload_t (coeffBlock_t),
        .DEPTH     (`FIFO_DEPTH)
    ) inFifo (
        .clk     (clk),
        .enc_rst (enc_rst),
        .wrValid (inValid),
        .wrData  (inData),
        .wrReady (inReady),
        .rdValid (blkValid),
        .rdData  (blkData),
        .rdReady (blkReady)
    );

    zeroRunScanner scanner (
        .clk        (clk),
        .enc_rst    (enc_rst),
        .codeEnable (codeEnable),
        .blkValid   (blkValid),
        .blkData    (blkData),
        .blkReady   (blkReady),
        .listValid  (listValid),
        .listData   (listData),
        .listReady  (listReady)
    );

    runBeforeEncoder encoder (
        .clk       (clk),
        .enc_rst   (enc_rst),
        .listValid (listValid),
        .listData  (listData),
        .listReady (listReady),
        .resValid  (resValid),
        .resData   (resData),
        .resReady  (resReady),
        .blockDone (blockDone)
    );

    syncFifo #(
        .payload_t (runCode_t),
        .DEPTH     (`FIFO_DEPTH)
    ) outFifo (
        .clk     (clk),
        .enc_rst (enc_rst),
        .wrValid (resValid),
        .wrData  (resData),
        .wrReady (resReady),
        .rdValid (outValid),
        .rdData  (outData),
        .rdReady (outReady)
    );

    // Bit count is final on the cycle blockDone pulses
    runCoderRegs regs (
        .clk        (clk),
        .enc_rst    (enc_rst),
        .axiReq     (axiReq),
        .axiRsp     (axiRsp),
        .blockDone  (blockDone),
        .doneBits   (resData.bits),
        .codeEnable (codeEnable)
    );

endmodule

/* testbench/cavlcRunCoder_props.sv */
`include "cavlc_consts.svh"

module cavlcRunCoder_props (
    input logic               clk,
    input logic               enc_rst,
    input logic               inValid,
    input logic               inReady,
    input logic               blkValid,
    input logic               blkReady,
    input logic               outValid,
    input logic               outReady,
    input cavlcPkg::runCode_t outData
);

    int inFill;

    // Input FIFO occupancy seen from its two handshakes
    always_ff @(posedge clk) begin
        if (enc_rst) begin
            inFill <= 0;
        end else begin
            inFill <= inFill + int'(inValid && inReady) - int'(blkValid && blkReady);
        end
    end

    outHeld: assert property (@(posedge clk) disable iff (enc_rst)
        outValid && !outReady |=> outValid && $stable(outData))
        else $error("outValid dropped or outData changed while outReady was low");

    bitsRange: assert property (@(posedge clk) disable iff (enc_rst)
        outValid |-> outData.bits <= `BITS_W'(`CODE_W))
        else $error("outData.bits above the code width");

    fullStall: assert property (@(posedge clk) disable iff (enc_rst)
        inFill == `FIFO_DEPTH |-> !inReady)
        else $error("inReady high while the input FIFO is full");

endmodule

bind cavlcRunCoder cavlcRunCoder_props props (
    .clk      (clk),
    .enc_rst  (enc_rst),
    .inValid  (inValid),
    .inReady  (inReady),
    .blkValid (blkValid),
    .blkReady (blkReady),
    .outValid (outValid),
    .outReady (outReady),
    .outData  (outData)
);

/* testbench/cavlcRunCoderTb.sv */
`include "cavlc_consts.svh"

module cavlcRunCoderTb;

    import cavlcPkg::*;

    localparam string TEST_FILE = "testbench/runCoderTests.txt";

    logic        clk;
    logic        enc_rst;
    logic        inValid;
    coeffBlock_t inData;
    logic        inReady;
    logic        outValid;
    runCode_t    outData;
    logic        outReady;
    axiLiteReq_t axiReq;
    axiLiteRsp_t axiRsp;

    coeffBlock_t blkQ[$];
    runCode_t    expQ[$];
    int          valueErrors;
    int          otherErrors;
    int          cycleLimit;
    int          cycles;
    bit          ctrlWritten;

    cavlcRunCoder UUT (
        .clk      (clk),
        .enc_rst  (enc_rst),
        .inValid  (inValid),
        .inData   (inData),
        .inReady  (inReady),
        .outValid (outValid),
        .outData  (outData),
        .outReady (outReady),
        .axiReq   (axiReq),
        .axiRsp   (axiRsp)
    );

    always #2 clk = ~clk;

    task automatic readTests();
        int          fd;
        int          n;
        string       line;
        logic [15:0] c [`BLK_COEFFS];
        int          tc;
        int          tz;
        int          nb;
        logic [31:0] code;
        coeffBlock_t blk;
        runCode_t    want;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the test file %s", TEST_FILE);
            otherErrors++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line,
                "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %d %d %h %d",
                c[0], c[1], c[2], c[3], c[4], c[5], c[6], c[7],
                c[8], c[9], c[10], c[11], c[12], c[13], c[14], c[15],
                tc, tz, code, nb);
            if (n != 20) begin
                $display("Malformed line in the test file: %s", line);
                otherErrors++;
            end else begin
                for (int i = 0; i < `BLK_COEFFS; i++) begin
                    blk[i] = c[i];
                end
                want.totalCoeff = 5'(tc);
                want.totalZeros = 5'(tz);
                want.code       = code;
                want.bits       = 6'(nb);
                blkQ.push_back(blk);
                expQ.push_back(want);
            end
        end
        $fclose(fd);
    endtask

    task automatic writeReg(input logic [3:0] addr, input logic [31:0] data);
        @(posedge clk);
        axiReq.awaddr  <= addr;
        axiReq.awvalid <= 1'b1;
        axiReq.wdata   <= data;
        axiReq.wstrb   <= 4'hf;
        axiReq.wvalid  <= 1'b1;
        axiReq.bready  <= 1'b1;
        do begin
            @(posedge clk);
        end while (!(axiRsp.awready && axiRsp.wready));
        axiReq.awvalid <= 1'b0;
        axiReq.wvalid  <= 1'b0;
        do begin
            @(posedge clk);
        end while (!axiRsp.bvalid);
        axiReq.bready <= 1'b0;
        if (axiRsp.bresp != 2'b00) begin
            $display("Fail at %0t: bresp 0x%0h on write to 0x%0h", $time, axiRsp.bresp, addr);
            valueErrors++;
        end
    endtask

    task automatic readReg(input logic [3:0] addr, output logic [31:0] data);
        @(posedge clk);
        axiReq.araddr  <= addr;
        axiReq.arvalid <= 1'b1;
        axiReq.rready  <= 1'b1;
        do begin
            @(posedge clk);
        end while (!axiRsp.arready);
        axiReq.arvalid <= 1'b0;
        do begin
            @(posedge clk);
        end while (!axiRsp.rvalid);
        data = axiRsp.rdata;
        axiReq.rready <= 1'b0;
        if (axiRsp.rresp != 2'b00) begin
            $display("Fail at %0t: rresp 0x%0h on read from 0x%0h", $time, axiRsp.rresp, addr);
            valueErrors++;
        end
    endtask

    task automatic expectReg(input logic [3:0] addr, input logic [31:0] want, input string name);
        logic [31:0] got;
        readReg(addr, got);
        if (got !== want) begin
            $display("Fail at %0t: %s read 0x%08h, expected 0x%08h", $time, name, got, want);
            valueErrors++;
        end
    endtask

    task automatic compareResult(input int idx, input runCode_t got, input runCode_t want);
        if (got.totalCoeff !== want.totalCoeff) begin
            $display("Fail at %0t: block %0d totalCoeff %0d, expected %0d",
                $time, idx, got.totalCoeff, want.totalCoeff);
            valueErrors++;
        end
        if (got.totalZeros !== want.totalZeros) begin
            $display("Fail at %0t: block %0d totalZeros %0d, expected %0d",
                $time, idx, got.totalZeros, want.totalZeros);
            valueErrors++;
        end
        if (got.code !== want.code) begin
            $display("Fail at %0t: block %0d code 0x%08h, expected 0x%08h",
                $time, idx, got.code, want.code);
            valueErrors++;
        end
        if (got.bits !== want.bits) begin
            $display("Fail at %0t: block %0d bits %0d, expected %0d",
                $time, idx, got.bits, want.bits);
            valueErrors++;
        end
    endtask

    task automatic sendBlocks();
        int sent;
        sent = 0;
        while (sent < blkQ.size()) begin
            @(posedge clk);
            if (inValid && inReady) begin
                sent++;
            end
            // A pending block stays on the bus until taken
            if (!inValid || inReady) begin
                if (sent < blkQ.size() && ($urandom % 4) != 0) begin
                    inValid <= 1'b1;
                    inData  <= blkQ[sent];
                end else begin
                    inValid <= 1'b0;
                end
            end
        end
    endtask

    task automatic collectResults();
        int received;
        received = 0;
        while (received < expQ.size()) begin
            @(posedge clk);
            if (outValid && !ctrlWritten) begin
                $display("A result came out before the coder was enabled");
                otherErrors++;
            end
            if (outValid && outReady) begin
                compareResult(received, outData, expQ[received]);
                received++;
            end
            outReady <= (($urandom % 3) != 0);
        end
        outReady <= 1'b0;
    endtask

    task automatic reportCounts();
        $display("Checks done: %0d value errors, %0d other errors", valueErrors, otherErrors);
    endtask

    initial begin
        clk         = 1'b0;
        enc_rst     = 1'b1;
        inValid     = 1'b0;
        inData      = '0;
        outReady    = 1'b0;
        axiReq      = '0;
        valueErrors = 0;
        otherErrors = 0;
        ctrlWritten = 1'b0;
        void'($urandom(32'hacb4db1d));
        readTests();
        cycleLimit = 40 * blkQ.size() + 200;
        repeat (2) @(posedge clk);
        enc_rst <= 1'b0;
        fork
            sendBlocks();
            collectResults();
            begin
                // Input FIFO fills while the coder is still disabled
                repeat (30) @(posedge clk);
                ctrlWritten = 1'b1;
                writeReg(`REG_CTRL, 32'd1);
            end
        join
        expectReg(`REG_CTRL, 32'd1, "CTRL");
        expectReg(`REG_BLKCNT, 32'(blkQ.size()), "BLKCNT");
        if (expQ.size() > 0) begin
            expectReg(`REG_LASTLEN, 32'(expQ[expQ.size() - 1].bits), "LASTLEN");
        end
        writeReg(`REG_BLKCNT, 32'hffff_ffff);
        expectReg(`REG_BLKCNT, 32'd0, "BLKCNT after clear");
        expectReg(4'hc, 32'd0, "unmapped offset");
        if (outValid) begin
            $display("An extra result is left in the output FIFO");
            otherErrors++;
        end
        reportCounts();
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        cycles = 0;
        @(posedge clk);
        while (cycles < cycleLimit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
        reportCounts();
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* cavlcRunCoder.f */
+incdir+logic
logic/cavlcPkg.sv
logic/syncFifo.sv
logic/zeroRunScanner.sv
logic/runBeforeEncoder.sv
logic/runCoderRegs.sv
logic/cavlcRunCoder.sv
testbench/cavlcRunCoder_props.sv
testbench/cavlcRunCoderTb.sv

/* runSim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --top-module cavlcRunCoderTb \
    -f cavlcRunCoder.f -o runCoderSim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/runCoderSim > sim.log 2>&1
cat sim.log
grep -qx "TEST PASSED" sim.log && exit 0 || exit 1

/* testbench/runCoderTests.txt */
# Columns: coefficients 0 to 15 in zigzag order (16-bit hex, two's complement),
# then TotalCoeff, TotalZeros (decimal), run_before code (hex, right-aligned), bits (decimal)
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0 0 00000000 0
0001 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 1 0 00000000 0
0000 0000 0000 0000 0000 0003 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 1 5 00000000 0
0001 ffff 0002 fffe 0001 0001 ffff 0003 0001 ffff 0001 0001 0002 ffff 0001 0001 16 0 00000000 0
0000 0003 ffff 0000 0000 ffff 0001 0000 0001 0000 0000 0000 0000 0000 0000 0000 5 4 0000005b 7
0005 fffd 0001 0001 0000 0000 0000 0000 0000 0000 0000 0000 0002 0000 0000 ffff 6 10 000000a1 8
0007 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 fff9 2 14 00000001 11
0001 0000 0000 0000 0000 0002 0000 0000 0000 ffff 0000 0000 0001 0000 0001 0001 6 10 00007d60 15
0004 0000 0000 0000 0001 0000 0000 ffff 0000 0001 0000 0000 0000 0000 0000 0000 4 6 0000000c 8
0000 0001 0000 0002 0000 0000 0000 0001 0000 0000 0000 0000 0000 0000 0000 0000 3 5 00000009 5
0001 0000 fffe 0000 0000 0000 0000 0000 0001 0000 0000 0000 0000 0000 0000 0000 3 6 0000000a 4
0003 0000 0000 0000 0000 0000 0000 0001 0000 0000 0000 0000 0000 0000 0000 0000 2 6 00000004 3
0000 0000 0001 0001 0000 0000 0000 0000 ffff 0001 0000 0000 0000 0000 0000 0000 4 6 00000035 6
0000 0002 0000 0000 0000 0001 0000 0000 0001 0000 0000 0000 0000 0000 0000 0000 3 6 00000009 6
0001 0000 0000 0000 0001 0000 0000 0001 0001 0000 0000 0000 0000 0000 0000 0000 4 5 0000006c 7
0002 0000 0001 0000 0000 0000 0000 ffff 0000 0000 0000 0000 0000 0000 0000 0000 3 5 00000002 4
0001 0000 0000 0000 0000 0000 0001 0000 0000 0000 0000 0000 0000 0000 0000 0000 2 5 00000000 3
0001 0000 0000 0001 0000 0001 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 3 3 00000008 4
0001 0000 0000 0000 0000 0001 ffff 0001 0000 0000 0000 0000 0000 0000 0000 0002 5 11 000000f8 11
0001 0001 0001 0000 0001 0001 0001 0001 0001 0001 0000 0001 0001 0001 0001 0001 14 2 00000f7e 12
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 8000 1 15 00000000 0
0000 0001 0000 0001 0000 0001 0000 0001 0000 0001 0000 0001 0000 0001 0000 0001 8 8 0001b0a9 17
